/* logic/block_integrator.sv */
// sums the weighted squares over one block with saturation
// reports the block sum and a 12-bit sharpness value after index 63
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module block_integrator (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     sq_valid,
    input  wire                     sq_first,
    input  wire                     sq_last,
    input  wire [16:0]              sq,
    output logic                    blk_done,
    output focus_pkg::blk_sum_t     blk_sum,
    output focus_pkg::sharp_t       blk_sharp
);
    logic [`FOCUS_BLK_SUM_W-1:0] acc;
    logic [`FOCUS_BLK_SUM_W:0]   sum_raw;  // one spare bit for overflow
    logic [`FOCUS_BLK_SUM_W-1:0] sum_sat;

    assign sum_raw = (sq_first ? '0 : {1'b0, acc}) + (`FOCUS_BLK_SUM_W+1)'(sq);
    assign sum_sat = sum_raw[`FOCUS_BLK_SUM_W] ? '1 : sum_raw[`FOCUS_BLK_SUM_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc      <= '0;
            blk_done <= 1'b0;
        end else begin
            blk_done <= sq_valid && sq_last;
            if (sq_valid) begin
                acc <= sum_sat;                  // first square restarts the sum
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sq_valid && sq_last) begin
            blk_sum   <= sum_sat;
            blk_sharp <= (|sum_sat[`FOCUS_BLK_SUM_W-1:20]) ? '1 : sum_sat[19:8]; // clip at 2^20
        end
    end

endmodule

`default_nettype wire

/* logic/block_locator.sv */
// tracks the macroblock column and row from the block stream
// flags each block as luma and as inside the window of interest
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module block_locator (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           blk_start,
    input  wire focus_pkg::blk_type_t     blk_type,
    input  wire                           frame_first,
    input  wire focus_pkg::pos_t          wnd_left,
    input  wire focus_pkg::pos_t          wnd_right,
    input  wire focus_pkg::pos_t          wnd_top,
    input  wire focus_pkg::pos_t          wnd_bottom,
    input  wire [`FOCUS_MBLK_W-1:0]       wnd_width,
    output logic                          luma,
    output logic                          in_woi
);
    import focus_pkg::*;

    logic [`FOCUS_MBLK_W-1:0] mblk_col;
    logic [`FOCUS_MBLK_W-1:0] mblk_row;
    logic [`FOCUS_MBLK_W-1:0] col_nxt;
    logic [`FOCUS_MBLK_W-1:0] row_nxt;
    logic                     mb_start;   // first block of a macroblock
    logic                     line_start;
    pos_t                     blk_col;
    pos_t                     blk_row;

    assign mb_start   = blk_start && (blk_type == 3'd0);
    assign line_start = frame_first || (mblk_col == wnd_width);

    always_comb begin
        col_nxt = mblk_col;
        row_nxt = mblk_row;
        if (mb_start) begin
            col_nxt = line_start ? '0 : mblk_col + 1'b1;
            if (line_start) begin
                row_nxt = frame_first ? '0 : mblk_row + 1'b1;
            end
        end
    end

    // position of the block now starting, in 8x8 block units
    assign blk_col = {col_nxt, blk_type[0]};
    assign blk_row = {row_nxt, blk_type[1]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mblk_col <= '0;
            mblk_row <= '0;
            luma     <= 1'b0;
            in_woi   <= 1'b0;
        end else begin
            mblk_col <= col_nxt;
            mblk_row <= row_nxt;
            if (blk_start) begin
                luma   <= !blk_type[2];
                in_woi <= (blk_col >= wnd_left) && (blk_col <= wnd_right) &&
                          (blk_row >= wnd_top)  && (blk_row <= wnd_bottom);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/coef_weighter.sv */
// weights each coefficient from the selected filter bank and squares it
// three stages: saturate + table read, multiply, magnitude scale + square
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module coef_weighter (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           coef_valid,
    input  wire                           blk_start,
    input  wire focus_pkg::coef_t         coef,
    input  wire [3:0]                     filt_sel,
    input  wire focus_pkg::weight_t       rd_data,
    output focus_pkg::tab_addr_t          rd_addr,
    output logic                          sq_valid,
    output logic                          sq_first,
    output logic                          sq_last,
    output logic [16:0]                   sq
);
    logic [5:0]                  idx_cnt;   // index of the next coefficient
    logic [5:0]                  idx_cur;
    logic [3:0]                  filt_blk;  // filter held for the whole block
    logic [3:0]                  filt_cur;
    logic                        v1, first1, last1, dc1;
    logic signed [11:0]          c1;
    logic [`FOCUS_WEIGHT_W-1:0]  w1;
    logic                        v2, first2, last2;
    logic signed [28:0]          p2;
    logic [28:0]                 mag2;
    logic [15:0]                 mag_sat;
    logic [31:0]                 sq_full;

    assign idx_cur  = blk_start ? 6'd0 : idx_cnt;
    assign filt_cur = blk_start ? filt_sel : filt_blk;
    assign rd_addr  = {filt_cur, idx_cur};           // filter * 64 + index

    assign w1      = dc1 ? '0 : rd_data;             // dc never contributes
    assign mag2    = p2[28] ? 29'(-p2) : 29'(p2);
    assign mag_sat = (|mag2[28:26]) ? 16'hffff : mag2[25:10]; // >> 10, clip to 17b signed
    assign sq_full = mag_sat * mag_sat;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_cnt  <= '0;
            filt_blk <= '0;
            v1       <= 1'b0;
            v2       <= 1'b0;
            sq_valid <= 1'b0;
        end else begin
            if (coef_valid) begin
                idx_cnt <= idx_cur + 1'b1;           // wraps to 0 after 63
            end
            if (blk_start) begin
                filt_blk <= filt_sel;
            end
            v1       <= coef_valid;
            v2       <= v1;
            sq_valid <= v2;
        end
    end

    // markers and data ride along with the valids
    always_ff @(posedge clk) begin
        first1   <= blk_start;
        last1    <= (idx_cur == 6'd63);
        dc1      <= (idx_cur == 6'd0);
        c1       <= (coef[12] == coef[11]) ? coef[11:0] : {coef[12], {11{coef[11]}}};
        first2   <= first1;
        last2    <= last1;
        p2       <= c1 * $signed({1'b0, w1});        // signed x unsigned weight
        sq_first <= first2;
        sq_last  <= last2;
        sq       <= {1'b0, sq_full[31:16]};          // square >> 16
    end

endmodule

`default_nettype wire

/* logic/focus_defines.svh */
// widths and fixed table locations shared by the focus sharpness core
// include in any file that sizes a port or decodes the window bank
`ifndef FOCUS_DEFINES_SVH
`define FOCUS_DEFINES_SVH

`define FOCUS_COEF_W      13  // coefficient input, signed
`define FOCUS_WEIGHT_W    16  // filter weight, unsigned
`define FOCUS_TAB_ADDR_W  10  // 16 banks of 64 weights
`define FOCUS_BLK_SUM_W   23  // saturating block sum of squares
`define FOCUS_FRAME_ACC_W 40  // frame accumulator
`define FOCUS_HIFREQ_W    32  // reported frame value, acc >> 8
`define FOCUS_SHARP_W     12  // per-block sharpness
`define FOCUS_POS_W       9   // block column/row in 8x8 blocks
`define FOCUS_MBLK_W      8   // macroblock counters
`define FOCUS_WND_BANK    15  // bank whose first words hold the window setup
`define FOCUS_PIPE_LAT    5   // last coef_valid to blk_valid, in clk cycles

`endif

/* logic/focus_pkg.sv */
// types shared across the focus sharpness core
// modules name these in port lists and import the package where the body needs them
`default_nettype none

`include "focus_defines.svh"

package focus_pkg;

    typedef logic signed [`FOCUS_COEF_W-1:0]   coef_t;     // dct coefficient
    typedef logic [`FOCUS_WEIGHT_W-1:0]        weight_t;   // filter table word
    typedef logic [`FOCUS_TAB_ADDR_W-1:0]      tab_addr_t; // {filter, coef index}
    typedef logic [`FOCUS_BLK_SUM_W-1:0]       blk_sum_t;
    typedef logic [`FOCUS_SHARP_W-1:0]         sharp_t;
    typedef logic [`FOCUS_POS_W-1:0]           pos_t;      // {macroblock, sub-block bit}
    typedef logic [2:0]                        blk_type_t; // 0..3 luma, 4..7 chroma

    // word offsets inside the window bank
    typedef enum logic [2:0] {
        WND_LEFT   = 3'd0,
        WND_RIGHT  = 3'd1,
        WND_TOP    = 3'd2,
        WND_BOTTOM = 3'd3,
        WND_WIDTH  = 3'd4,
        WND_FILTER = 3'd5
    } wnd_reg_e;

endpackage

`default_nettype wire

/* logic/focus_tables.sv */
// weight memory written from the parallel table port, read once per clock
// writes into the window bank also load the window and filter-select registers
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module focus_tables (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          tab_we,
    input  wire focus_pkg::tab_addr_t    tab_addr,
    input  wire focus_pkg::weight_t      tab_data,
    input  wire focus_pkg::tab_addr_t    rd_addr,
    output focus_pkg::weight_t           rd_data,
    output focus_pkg::pos_t              wnd_left,
    output focus_pkg::pos_t              wnd_right,
    output focus_pkg::pos_t              wnd_top,
    output focus_pkg::pos_t              wnd_bottom,
    output logic [`FOCUS_MBLK_W-1:0]     wnd_width,
    output logic [3:0]                   filt_sel
);
    import focus_pkg::*;

    weight_t  mem [1 << `FOCUS_TAB_ADDR_W]; // 16 filters x 64 coefficients
    logic     wnd_hit;
    wnd_reg_e wnd_sel;

    assign wnd_hit = tab_we && (tab_addr[`FOCUS_TAB_ADDR_W-1:6] == 4'(`FOCUS_WND_BANK))
                     && (tab_addr[5:3] == 3'd0);  // words 0..7 of the last bank
    assign wnd_sel = wnd_reg_e'(tab_addr[2:0]);

    always_ff @(posedge clk) begin
        if (tab_we) begin
            mem[tab_addr] <= tab_data;           // bank 15 keeps the words as well
        end
        rd_data <= mem[rd_addr];                 // registered read, one cycle
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wnd_left   <= '0;
            wnd_right  <= '0;
            wnd_top    <= '0;
            wnd_bottom <= '0;
            wnd_width  <= '0;
            filt_sel   <= '0;
        end else if (wnd_hit) begin
            case (wnd_sel)
                WND_LEFT:   wnd_left   <= tab_data[`FOCUS_POS_W-1:0];  // inclusive bounds
                WND_RIGHT:  wnd_right  <= tab_data[`FOCUS_POS_W-1:0];
                WND_TOP:    wnd_top    <= tab_data[`FOCUS_POS_W-1:0];
                WND_BOTTOM: wnd_bottom <= tab_data[`FOCUS_POS_W-1:0];
                WND_WIDTH:  wnd_width  <= tab_data[`FOCUS_MBLK_W-1:0]; // mblk per line - 1
                WND_FILTER: filt_sel   <= tab_data[3:0];
                default: begin
                end                                                     // words 6,7 unused
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/focus_top.sv */
// focus sharpness core: weights dct blocks, sums squares per block and per frame
// tables and window are loaded through tab_we/tab_addr/tab_data before block traffic
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module focus_top (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          tab_we,
    input  wire focus_pkg::tab_addr_t    tab_addr,
    input  wire focus_pkg::weight_t      tab_data,
    input  wire                          blk_start,
    input  wire focus_pkg::blk_type_t    blk_type,
    input  wire                          frame_first,
    input  wire                          frame_last,
    input  wire                          coef_valid,
    input  wire focus_pkg::coef_t        coef,
    output logic                         blk_valid,
    output focus_pkg::sharp_t            blk_sharp,
    output logic                         hifreq_valid,
    output logic [`FOCUS_HIFREQ_W-1:0]   hifreq
);
    import focus_pkg::*;

    tab_addr_t                rd_addr;
    weight_t                  rd_data;
    pos_t                     wnd_left, wnd_right, wnd_top, wnd_bottom;
    logic [`FOCUS_MBLK_W-1:0] wnd_width;
    logic [3:0]               filt_sel;
    logic                     luma, in_woi;
    logic                     sq_valid, sq_first, sq_last;
    logic [16:0]              sq;
    logic                     blk_done;
    blk_sum_t                 blk_sum;

    focus_tables u_tables (
        .clk        (clk),
        .arst_n     (arst_n),
        .tab_we     (tab_we),
        .tab_addr   (tab_addr),
        .tab_data   (tab_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .wnd_left   (wnd_left),
        .wnd_right  (wnd_right),
        .wnd_top    (wnd_top),
        .wnd_bottom (wnd_bottom),
        .wnd_width  (wnd_width),
        .filt_sel   (filt_sel)
    );

    block_locator u_locator (
        .clk         (clk),
        .arst_n      (arst_n),
        .blk_start   (blk_start),
        .blk_type    (blk_type),
        .frame_first (frame_first),
        .wnd_left    (wnd_left),
        .wnd_right   (wnd_right),
        .wnd_top     (wnd_top),
        .wnd_bottom  (wnd_bottom),
        .wnd_width   (wnd_width),
        .luma        (luma),
        .in_woi      (in_woi)
    );

    coef_weighter u_weighter (
        .clk        (clk),
        .arst_n     (arst_n),
        .coef_valid (coef_valid),
        .blk_start  (blk_start),
        .coef       (coef),
        .filt_sel   (filt_sel),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .sq_valid   (sq_valid),
        .sq_first   (sq_first),
        .sq_last    (sq_last),
        .sq         (sq)
    );

    block_integrator u_blk_int (
        .clk       (clk),
        .arst_n    (arst_n),
        .sq_valid  (sq_valid),
        .sq_first  (sq_first),
        .sq_last   (sq_last),
        .sq        (sq),
        .blk_done  (blk_done),
        .blk_sum   (blk_sum),
        .blk_sharp (blk_sharp)
    );

    frame_integrator u_frame_int (
        .clk          (clk),
        .arst_n       (arst_n),
        .blk_start    (blk_start),
        .luma         (luma),
        .in_woi       (in_woi),
        .frame_first  (frame_first),
        .frame_last   (frame_last),
        .blk_done     (blk_done),
        .blk_sum      (blk_sum),
        .blk_valid    (blk_valid),
        .hifreq_valid (hifreq_valid),
        .hifreq       (hifreq)
    );

endmodule

`default_nettype wire

/* logic/frame_integrator.sv */
// carries per-block flags to the end of the pipeline and builds the frame sum
// in-window luma block sums add up; the total is reported on the last block
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module frame_integrator (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          blk_start,
    input  wire                          luma,
    input  wire                          in_woi,
    input  wire                          frame_first,
    input  wire                          frame_last,
    input  wire                          blk_done,
    input  wire focus_pkg::blk_sum_t     blk_sum,
    output logic                         blk_valid,
    output logic                         hifreq_valid,
    output logic [`FOCUS_HIFREQ_W-1:0]   hifreq
);
    logic                           start_d;     // luma/in_woi valid now
    logic                           ff_d, fl_d;
    logic [3:0]                     flag_q [2];  // {luma, in_woi, first, last}, two in flight
    logic                           wr_ptr, rd_ptr;
    logic [3:0]                     head;
    logic [`FOCUS_FRAME_ACC_W-1:0]  acc;
    logic [`FOCUS_FRAME_ACC_W-1:0]  acc_base;
    logic                           last_pend;   // frame total ready next cycle

    assign head     = flag_q[rd_ptr];
    assign acc_base = head[1] ? '0 : acc;        // first block of a frame restarts

    always_ff @(posedge clk) begin
        if (blk_start) begin
            ff_d <= frame_first;
            fl_d <= frame_last;
        end
        if (start_d) begin
            flag_q[wr_ptr] <= {luma, in_woi, ff_d, fl_d};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_d      <= 1'b0;
            wr_ptr       <= 1'b0;
            rd_ptr       <= 1'b0;
            acc          <= '0;
            blk_valid    <= 1'b0;
            last_pend    <= 1'b0;
            hifreq_valid <= 1'b0;
            hifreq       <= '0;
        end else begin
            start_d <= blk_start;
            if (start_d) begin
                wr_ptr <= ~wr_ptr;
            end
            if (blk_done) begin
                rd_ptr <= ~rd_ptr;
                acc    <= acc_base + ((head[3] && head[2]) ? `FOCUS_FRAME_ACC_W'(blk_sum) : '0);
            end
            blk_valid    <= blk_done && head[3]; // chroma blocks stay silent
            last_pend    <= blk_done && head[0];
            hifreq_valid <= last_pend;
            if (last_pend) begin
                hifreq <= acc[`FOCUS_FRAME_ACC_W-1:8];
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the focus testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module focus_tb -f tb.f \
    && ./obj_dir/Vfocus_tb > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^All tests passed$" sim.log && echo "RESULT: PASS" && exit 0 \
    || { echo "RESULT: FAIL"; exit 1; }

/* sim/focus_assertions.sv */
// timing checks on the focus_top block and frame strobes
// bound into every focus_top instance by the bind below
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module focus_assertions (
    input wire                       clk,
    input wire                       arst_n,
    input wire                       blk_start,
    input wire focus_pkg::blk_type_t blk_type,
    input wire                       coef_valid,
    input wire                       blk_valid,
    input wire                       hifreq_valid
);
    logic [5:0] idx_cnt;       // coefficients seen so far in this block
    logic       luma_q;
    logic       coef_seen;
    logic       last_luma;     // index 63 of a luma block arriving now
    int         fail_cnt = 0;  // failed checks so far

    assign last_luma = coef_valid && ((blk_start ? 6'd0 : idx_cnt) == 6'd63) &&
                       (blk_start ? !blk_type[2] : luma_q);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_cnt   <= '0;
            luma_q    <= 1'b0;
            coef_seen <= 1'b0;
        end else begin
            if (coef_valid) begin
                idx_cnt   <= (blk_start ? 6'd0 : idx_cnt) + 6'd1;
                coef_seen <= 1'b1;
            end
            if (blk_start) begin
                luma_q <= !blk_type[2];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
                     blk_valid == $past(last_luma, `FOCUS_PIPE_LAT))
        else begin
            fail_cnt++;
            $error("blk_valid not 5 cycles after the last luma coefficient");
        end
    assert property (@(posedge clk) !arst_n |-> !hifreq_valid)
        else begin
            fail_cnt++;
            $error("hifreq_valid high during reset");
        end
    assert property (@(posedge clk) disable iff (!arst_n) blk_valid |-> coef_seen)
        else begin
            fail_cnt++;
            $error("blk_valid before any coefficient");
        end

endmodule

bind focus_top focus_assertions u_assertions (
    .clk          (clk),
    .arst_n       (arst_n),
    .blk_start    (blk_start),
    .blk_type     (blk_type),
    .coef_valid   (coef_valid),
    .blk_valid    (blk_valid),
    .hifreq_valid (hifreq_valid)
);

`default_nettype wire

/* sim/focus_tb.sv */
// testbench for focus_top that loads filter tables, streams dct blocks and checks
// blk_sharp at each blk_valid and hifreq at each hifreq_valid against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "focus_defines.svh"

module focus_tb;
    import focus_pkg::*;

    localparam int BLOCKS_SENT    = 44;  // 4 + 1 + 3 + 32 + 4 over all tests
    localparam int GAP_BLOCKS     = 4;   // these see up to 2 idle cycles per coefficient
    localparam int TIMEOUT_CYCLES = BLOCKS_SENT * 64 + GAP_BLOCKS * 64 * 2 + 600;
    localparam int WND_BASE       = `FOCUS_WND_BANK * 64;

    logic                       clk, arst_n, tab_we;
    logic                       blk_start, frame_first, frame_last, coef_valid;
    tab_addr_t                  tab_addr;
    weight_t                    tab_data;
    blk_type_t                  blk_type;
    coef_t                      coef;
    logic                       blk_valid, hifreq_valid;
    sharp_t                     blk_sharp;
    logic [`FOCUS_HIFREQ_W-1:0] hifreq;

    int          weights [1 << `FOCUS_TAB_ADDR_W];  // copy of what was written
    int          blk_coef [64];                     // block about to be sent
    int          saved [4][64];                     // reused with gaps later
    int          cur_filt;
    longint      frame_acc;
    int unsigned lcg_state = 44;
    int          exp_sharp [$];
    longint      exp_hifreq [$];
    int          want_sharp;
    longint      want_hifreq;
    string       test_name;
    int          errors, checks, cycle_cnt;

    focus_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;  // low bits of an lcg repeat quickly
    endfunction

    function automatic void random_block();
        int i;
        for (i = 0; i < 64; i++) begin
            blk_coef[i] = int'(lcg_next() % 1024) - 512;
        end
    endfunction

    // block sum of squares as the weighting rules define it
    function automatic longint block_ref(input int filt);
        longint sum, cv, w, p, mag, m;
        int i;
        sum = 0;
        for (i = 0; i < 64; i++) begin
            cv  = blk_coef[i];
            cv  = (cv > 2047) ? 2047 : ((cv < -2048) ? -2048 : cv);  // 12b signed
            w   = (i == 0) ? 0 : weights[filt * 64 + i];            // dc weight is zero
            p   = cv * w;
            mag = (p < 0) ? -p : p;
            m   = mag / 1024;
            if (m > 65535) m = 65535;                               // 17b signed limit
            sum = sum + (m * m) / 65536;
            if (sum > 8388607) sum = 8388607;                       // 2^23 - 1
        end
        return sum;
    endfunction

    function automatic int sharp_of(input longint sum);
        return (sum >= 1048576) ? 4095 : int'(sum / 256);
    endfunction

    task automatic write_table(input int addr, input int data);
        @(posedge clk);
        #1;
        tab_we        = 1'b1;
        tab_addr      = tab_addr_t'(addr);
        tab_data      = weight_t'(data);
        coef_valid    = 1'b0;
        blk_start     = 1'b0;
        weights[addr] = data;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            tab_we      = 1'b0;
            coef_valid  = 1'b0;
            blk_start   = 1'b0;
            frame_first = 1'b0;
            frame_last  = 1'b0;
        end
    endtask

    task automatic set_window(input int l, input int r, input int t, input int b, input int w);
        write_table(WND_BASE + int'(WND_LEFT), l);    // inclusive block bounds
        write_table(WND_BASE + int'(WND_RIGHT), r);
        write_table(WND_BASE + int'(WND_TOP), t);
        write_table(WND_BASE + int'(WND_BOTTOM), b);
        write_table(WND_BASE + int'(WND_WIDTH), w);   // macroblocks per line - 1
    endtask

    task automatic select_filter(input int f);
        write_table(WND_BASE + int'(WND_FILTER), f);
        cur_filt = f;
    endtask

    // queues the expected results, then streams blk_coef
    task automatic send_block(input int btype, input bit ff, input bit fl, input bit woi,
                              input bit gaps);
        longint sum;
        int i;
        sum = block_ref(cur_filt);
        if (btype < 4) exp_sharp.push_back(sharp_of(sum));   // luma only
        if (ff) frame_acc = 0;
        if (btype < 4 && woi) frame_acc = frame_acc + sum;
        if (fl) exp_hifreq.push_back((frame_acc >> 8) & 64'hffffffff);
        for (i = 0; i < 64; i++) begin
            if (gaps && i > 0) idle(int'(lcg_next() % 3));
            @(posedge clk);
            #1;
            tab_we      = 1'b0;
            coef_valid  = 1'b1;
            coef        = coef_t'(blk_coef[i]);
            blk_start   = (i == 0);
            blk_type    = blk_type_t'(btype);
            frame_first = ff && (i == 0);
            frame_last  = fl && (i == 0);
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_sharp.size() != 0 || exp_hifreq.size() != 0) begin
            @(posedge clk);
        end
        idle(2);
    endtask

    // outputs are registered on the rising edge, sampled half a cycle later
    always @(negedge clk) begin
        if (arst_n && blk_valid) begin
            if (exp_sharp.size() == 0) begin
                $display("%s: blk_valid pulsed with no luma block pending", test_name);
                errors++;
            end else begin
                want_sharp = exp_sharp.pop_front();
                checks++;
                if (blk_sharp != sharp_t'(want_sharp)) begin
                    $display("Error: %s blk_sharp expected %0d actual %0d",
                             test_name, want_sharp, blk_sharp);
                    errors++;
                end
            end
        end
        if (arst_n && hifreq_valid) begin
            if (exp_hifreq.size() == 0) begin
                $display("%s: hifreq_valid pulsed with no frame end pending", test_name);
                errors++;
            end else begin
                want_hifreq = exp_hifreq.pop_front();
                checks++;
                if (hifreq != 32'(want_hifreq)) begin
                    $display("Error: %s hifreq expected %0d actual %0d",
                             test_name, want_hifreq, hifreq);
                    errors++;
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int a, b, f, r, c, t, col, row;
        tab_we      = 1'b0;
        tab_addr    = '0;
        tab_data    = '0;
        blk_start   = 1'b0;
        blk_type    = '0;
        frame_first = 1'b0;
        frame_last  = 1'b0;
        coef_valid  = 1'b0;
        coef        = '0;
        arst_n      = 1'b0;
        errors      = 0;
        checks      = 0;
        cur_filt    = 0;
        frame_acc   = 0;
        test_name   = "reset";
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            checks++;
            if (blk_valid || hifreq_valid || hifreq != '0) begin
                $display("Error: %s outputs expected 0 0 0 actual %0b %0b %0d",
                         test_name, blk_valid, hifreq_valid, hifreq);
                errors++;
            end
        end

        test_name = "random luma";
        for (a = 0; a < 64; a++) write_table(3 * 64 + a, int'(lcg_next() % 65536));
        select_filter(3);
        for (b = 0; b < 3; b++) begin
            random_block();
            saved[b] = blk_coef;
            send_block(1, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        blk_coef    = '{default: 0};
        blk_coef[0] = 1500;                      // dc only gives sharpness 0
        saved[3]    = blk_coef;
        send_block(1, 1'b0, 1'b0, 1'b0, 1'b0);
        drain();

        test_name = "saturation";
        for (a = 0; a < 64; a++) write_table(5 * 64 + a, 65535);
        select_filter(5);
        for (a = 0; a < 64; a++) blk_coef[a] = (a % 2 != 0) ? 4095 : -4096;
        send_block(2, 1'b0, 1'b0, 1'b0, 1'b0);
        drain();
        select_filter(3);

        // window still all zero from reset, so only block (0,0) counts
        test_name = "chroma";
        random_block();
        send_block(0, 1'b1, 1'b0, 1'b1, 1'b0);
        random_block();
        send_block(4, 1'b0, 1'b0, 1'b0, 1'b0);
        random_block();
        send_block(5, 1'b0, 1'b1, 1'b0, 1'b0);
        drain();

        test_name = "two frames";
        set_window(1, 2, 1, 2, 1);               // centre 2x2 blocks of a 4x4 block frame
        for (f = 0; f < 2; f++) begin
            for (r = 0; r < 2; r++) begin
                for (c = 0; c < 2; c++) begin
                    for (t = 0; t < 4; t++) begin
                        col = 2 * c + t % 2;
                        row = 2 * r + t / 2;
                        random_block();
                        send_block(t, (r == 0 && c == 0 && t == 0), (r == 1 && c == 1 && t == 3),
                                   (col >= 1 && col <= 2 && row >= 1 && row <= 2), 1'b0);
                    end
                end
            end
        end
        drain();

        test_name = "coefficient gaps";
        for (b = 0; b < 4; b++) begin
            blk_coef = saved[b];
            send_block(1, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        drain();

        errors = errors + UUT.u_assertions.fail_cnt;  // bound assertion failures count too
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/focus_pkg.sv
logic/focus_tables.sv
logic/block_locator.sv
logic/coef_weighter.sv
logic/block_integrator.sv
logic/frame_integrator.sv
logic/focus_top.sv
sim/focus_assertions.sv
sim/focus_tb.sv
